/* hw/rv_isa_pkg.sv */
// RV32I subset encodings with opcodes, funct codes, the bubble word and the instruction union
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;               // Data and address width

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;    // x0..x31

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,            // Register ALU
        opc_op_imm = 7'b0010011,            // Immediate ALU
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,            // beq only
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

    // ====================================================================
    // funct3 and funct7 values
    // ====================================================================
    localparam logic [2:0] f3_add  = 3'b000;    // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;    // srl and sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Access sizes, stores use the same low two bits
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    localparam logic [6:0] funct7_alt = 7'b0100000;  // Marks sub and sra
    localparam word_t      nop_word   = 32'h0000_0013; // addi x0, x0, 0

    // ====================================================================
    // Instruction formats
    // ====================================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;       // Upper 20 bits
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        reg_addr_t   rd;
        opcode_t     opcode;
    } j_fmt_t;

    // One fetched word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire

/* hw/rv_pipe_pkg.sv */
// Pipeline package with memory sizes, ALU functions, control bundle and stage registers
`default_nettype none

package rv_pipe_pkg;

    localparam int imem_words = 128;
    localparam int dmem_words = 128;
    localparam int imem_aw    = $clog2(imem_words);  // Word index bits
    localparam int dmem_aw    = $clog2(dmem_words);

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_t;

    // Decoded controls, all zero means bubble
    typedef struct packed {
        logic       alu_src;     // Operand b from immediate
        logic       imm_load;    // lui
        logic       branch;
        logic       jump;        // jal or jalr
        logic       jump_reg;    // Target base is rs1
        logic       link;        // Result is pc + 4
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       mem_to_reg;
        logic [2:0] size;        // Load/store funct3
    } ctrl_t;

    // ====================================================================
    // Stage registers
    // ====================================================================
    typedef struct packed {
        rv_isa_pkg::word_t  pc;
        rv_isa_pkg::instr_u instr;
    } if_id_t;

    typedef struct packed {
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::word_t     rs1_val;
        rv_isa_pkg::word_t     rs2_val;
        rv_isa_pkg::word_t     imm;
        logic [9:0]            funct;    // {funct7, funct3}
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        rv_isa_pkg::word_t     target;   // Branch or jump destination
        logic                  zero;
        rv_isa_pkg::word_t     result;   // ALU result or link address
        rv_isa_pkg::word_t     store_data;
        rv_isa_pkg::reg_addr_t rd;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        rv_isa_pkg::word_t     load_data;
        rv_isa_pkg::word_t     result;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_write;
        logic                  mem_to_reg;
    } mem_wb_t;

    typedef struct packed {
        logic              taken;
        rv_isa_pkg::word_t target;
    } redirect_t;

    // Final writeback, also the MEM/WB forwarding source
    typedef struct packed {
        logic                  we;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* hw/rv_fetch.sv */
// Fetch stage with program counter, instruction ROM, bubble insertion and IF/ID register
`default_nettype none

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,       // Level, PC advances while high
    input  rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::if_id_t    if_id
);

    rv_isa_pkg::word_t  pc;
    rv_isa_pkg::word_t  pc_next;
    rv_isa_pkg::word_t  rom [rv_pipe_pkg::imem_words];
    rv_isa_pkg::instr_u fetch_word;

    initial begin
        $readmemh("dv/program.hex", rom);   // Program image
    end

    // Redirect wins over sequential advance
    assign pc_next = redirect.taken ? redirect.target :
                     run            ? pc + 32'd4      : pc;

    // Squash the fetched word on redirect
    assign fetch_word = redirect.taken ? rv_isa_pkg::nop_word
                                       : rom[pc[rv_pipe_pkg::imem_aw+1:2]];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= '0;
            if_id <= '0;          // Decodes as a bubble
        end else begin
            pc          <= pc_next;
            if_id.pc    <= pc;
            if_id.instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
// Decode stage with control decoder, immediate generator, register file, writeback and ID/EX
`default_nettype none

module rv_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::if_id_t    if_id,
    input  rv_pipe_pkg::mem_wb_t   mem_wb,
    input  rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::id_ex_t    id_ex,
    output rv_pipe_pkg::wb_t       wb
);

    rv_isa_pkg::instr_u    instr;
    rv_pipe_pkg::ctrl_t    ctrl;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::word_t     regs [32];
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::word_t     rs1_val;
    rv_isa_pkg::word_t     rs2_val;

    assign instr = if_id.instr;

    // ====================================================================
    // Control decoder
    // ====================================================================
    always_comb begin
        ctrl = '0;
        case (instr.r_fmt.opcode)
            rv_isa_pkg::opc_op:     ctrl = '{reg_write: 1'b1, default: '0};
            rv_isa_pkg::opc_op_imm: ctrl = '{alu_src: 1'b1, reg_write: 1'b1, default: '0};
            rv_isa_pkg::opc_lui:
                ctrl = '{alu_src: 1'b1, imm_load: 1'b1, reg_write: 1'b1, default: '0};
            rv_isa_pkg::opc_load:
                ctrl = '{alu_src: 1'b1, mem_read: 1'b1, reg_write: 1'b1, mem_to_reg: 1'b1,
                         size: instr.r_fmt.funct3, default: '0};
            rv_isa_pkg::opc_store:
                ctrl = '{alu_src: 1'b1, mem_write: 1'b1, size: instr.r_fmt.funct3,
                         default: '0};
            rv_isa_pkg::opc_branch: ctrl = '{branch: 1'b1, default: '0};   // ALU subtracts
            rv_isa_pkg::opc_jal:
                ctrl = '{jump: 1'b1, link: 1'b1, reg_write: 1'b1, default: '0};
            rv_isa_pkg::opc_jalr:
                ctrl = '{alu_src: 1'b1, jump: 1'b1, jump_reg: 1'b1, link: 1'b1,
                         reg_write: 1'b1, default: '0};
            default: ctrl = '0;     // Unknown word acts as bubble
        endcase
    end

    // Immediate per format
    always_comb begin
        case (instr.r_fmt.opcode)
            rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_load, rv_isa_pkg::opc_jalr:
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            rv_isa_pkg::opc_store:
                imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            rv_isa_pkg::opc_branch:
                imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            rv_isa_pkg::opc_lui: imm = {instr.u_fmt.imm, 12'h000};
            rv_isa_pkg::opc_jal:
                imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    // ====================================================================
    // Register file with write-before-read bypass
    // ====================================================================
    assign wb.we   = mem_wb.reg_write;
    assign wb.rd   = mem_wb.rd;
    assign wb.data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

    assign rs1 = ctrl.imm_load ? '0 : instr.r_fmt.rs1;   // lui reads x0 so the add yields imm

    assign rs1_val = (wb.we && wb.rd != '0 && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_val = (wb.we && wb.rd != '0 && wb.rd == instr.r_fmt.rs2) ? wb.data
                                                                         : regs[instr.r_fmt.rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wb.we && wb.rd != '0) begin   // x0 stays zero
            regs[wb.rd] <= wb.data;
        end
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else begin
            id_ex.pc      <= if_id.pc;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.imm     <= imm;
            id_ex.funct   <= {instr.r_fmt.funct7, instr.r_fmt.funct3};
            id_ex.rs1     <= rs1;
            id_ex.rs2     <= instr.r_fmt.rs2;
            id_ex.rd      <= instr.r_fmt.rd;
            id_ex.ctrl    <= redirect.taken ? '0 : ctrl;   // Squash on redirect
        end
    end

    // Reads of x0 see zero through the array and the bypass
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1 != '0 || rs1_val == '0) && (instr.r_fmt.rs2 != '0 || rs2_val == '0));

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
// Execute stage with forwarding, ALU control, ALU, target adder and EX/MEM register
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::id_ex_t    id_ex,
    input  rv_pipe_pkg::wb_t       wb,
    input  rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::ex_mem_t   ex_mem
);

    rv_pipe_pkg::alu_op_t alu_op;
    rv_isa_pkg::word_t    op_a;
    rv_isa_pkg::word_t    rs2_fwd;
    rv_isa_pkg::word_t    op_b;
    rv_isa_pkg::word_t    alu_res;
    rv_isa_pkg::word_t    target_sum;
    logic [6:0]           funct7;
    logic [2:0]           funct3;
    logic                 addr_calc;

    // Producer hit, never for x0
    function automatic logic hit(input logic we, input rv_isa_pkg::reg_addr_t rd,
                                 input rv_isa_pkg::reg_addr_t rs);
        return we && rd != '0 && rd == rs;
    endfunction

    // ====================================================================
    // Forwarding, EX/MEM is younger so it wins
    // ====================================================================
    assign op_a = hit(ex_mem.ctrl.reg_write, ex_mem.rd, id_ex.rs1) ? ex_mem.result :
                  hit(wb.we, wb.rd, id_ex.rs1)                      ? wb.data       :
                                                                      id_ex.rs1_val;
    assign rs2_fwd = hit(ex_mem.ctrl.reg_write, ex_mem.rd, id_ex.rs2) ? ex_mem.result :
                     hit(wb.we, wb.rd, id_ex.rs2)                      ? wb.data       :
                                                                         id_ex.rs2_val;
    assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;

    // ALU control
    assign funct7    = id_ex.funct[9:3];
    assign funct3    = id_ex.funct[2:0];
    assign addr_calc = id_ex.ctrl.mem_read | id_ex.ctrl.mem_write | id_ex.ctrl.imm_load;

    always_comb begin
        alu_op = rv_pipe_pkg::alu_add;      // Loads, stores, lui
        if (id_ex.ctrl.branch) begin
            alu_op = rv_pipe_pkg::alu_sub;  // beq compares by difference
        end else if (!addr_calc && !id_ex.ctrl.link) begin
            case (funct3)
                rv_isa_pkg::f3_add:
                    alu_op = (!id_ex.ctrl.alu_src && funct7 == rv_isa_pkg::funct7_alt)
                             ? rv_pipe_pkg::alu_sub : rv_pipe_pkg::alu_add;
                rv_isa_pkg::f3_sll:  alu_op = rv_pipe_pkg::alu_sll;
                rv_isa_pkg::f3_slt:  alu_op = rv_pipe_pkg::alu_slt;
                rv_isa_pkg::f3_sltu: alu_op = rv_pipe_pkg::alu_sltu;
                rv_isa_pkg::f3_xor:  alu_op = rv_pipe_pkg::alu_xor;
                rv_isa_pkg::f3_srl:
                    alu_op = (funct7 == rv_isa_pkg::funct7_alt) ? rv_pipe_pkg::alu_sra
                                                                : rv_pipe_pkg::alu_srl;
                rv_isa_pkg::f3_or:   alu_op = rv_pipe_pkg::alu_or;
                default:             alu_op = rv_pipe_pkg::alu_and;
            endcase
        end
    end

    // ====================================================================
    // ALU and target adder
    // ====================================================================
    always_comb begin
        case (alu_op)
            rv_pipe_pkg::alu_sub:  alu_res = op_a - op_b;
            rv_pipe_pkg::alu_and:  alu_res = op_a & op_b;
            rv_pipe_pkg::alu_or:   alu_res = op_a | op_b;
            rv_pipe_pkg::alu_xor:  alu_res = op_a ^ op_b;
            rv_pipe_pkg::alu_slt:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pipe_pkg::alu_sltu: alu_res = {31'd0, op_a < op_b};
            rv_pipe_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
            rv_pipe_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
            rv_pipe_pkg::alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:               alu_res = op_a + op_b;
        endcase
    end

    assign target_sum = (id_ex.ctrl.jump_reg ? op_a : id_ex.pc) + id_ex.imm;  // jalr uses rs1

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.target     <= {target_sum[31:1], 1'b0};
            ex_mem.zero       <= (alu_res == '0);
            ex_mem.result     <= id_ex.ctrl.link ? id_ex.pc + 32'd4 : alu_res;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.ctrl       <= redirect.taken ? '0 : id_ex.ctrl;
        end
    end

    // Any decoded register writer selects a real ALU function
    a_alu_op_known: assert property (@(posedge clk) disable iff (rst)
        id_ex.ctrl.reg_write |-> !$isunknown(alu_op));

endmodule

`default_nettype wire

/* hw/rv_memory.sv */
// Memory stage with size-aware data RAM, redirect decision and MEM/WB register
`default_nettype none

module rv_memory (
    input  logic                           clk,
    input  logic                           rst,
    input  rv_pipe_pkg::ex_mem_t           ex_mem,
    output rv_pipe_pkg::redirect_t         redirect,
    output rv_pipe_pkg::mem_wb_t           mem_wb,
    output logic [rv_isa_pkg::xlen-1:0]    data_mem0
);

    rv_isa_pkg::word_t            ram [rv_pipe_pkg::dmem_words];
    logic [rv_pipe_pkg::dmem_aw-1:0] idx;
    logic [1:0]                   lane;
    rv_isa_pkg::word_t            lane_word;
    rv_isa_pkg::word_t            load_data;

    assign idx  = ex_mem.result[rv_pipe_pkg::dmem_aw+1:2];   // Word address
    assign lane = ex_mem.result[1:0];                        // Byte in word

    // Selected lane moved to bit 0
    assign lane_word = ram[idx] >> {lane, 3'b000};

    always_comb begin
        case (ex_mem.ctrl.size)
            rv_isa_pkg::f3_lb:  load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            rv_isa_pkg::f3_lh:  load_data = {{16{lane_word[15]}}, lane_word[15:0]};
            rv_isa_pkg::f3_lbu: load_data = {24'd0, lane_word[7:0]};
            rv_isa_pkg::f3_lhu: load_data = {16'd0, lane_word[15:0]};
            default:            load_data = lane_word;   // lw
        endcase
    end

    // Store merges only the addressed lane
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv_pipe_pkg::dmem_words; i++) ram[i] <= '0;
        end else if (ex_mem.ctrl.mem_write) begin
            case (ex_mem.ctrl.size[1:0])
                2'b00:   ram[idx][{lane, 3'b000} +: 8]     <= ex_mem.store_data[7:0];
                2'b01:   ram[idx][{lane[1], 4'b0000} +: 16] <= ex_mem.store_data[15:0];
                default: ram[idx]                          <= ex_mem.store_data;
            endcase
        end
    end

    assign data_mem0 = ram[0];   // Status word

    // Jumps always, beq on equal
    assign redirect.taken  = ex_mem.ctrl.jump | (ex_mem.ctrl.branch & ex_mem.zero);
    assign redirect.target = ex_mem.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.load_data  <= load_data;
            mem_wb.result     <= ex_mem.result;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
        end
    end

    // Address from execute must suit the access size
    a_half_aligned: assert property (@(posedge clk) disable iff (rst)
        ((ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write) && ex_mem.ctrl.size[1:0] == 2'b01)
        |-> !lane[0]);
    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        ((ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write) && ex_mem.ctrl.size[1:0] == 2'b10)
        |-> lane == 2'b00);

endmodule

`default_nettype wire

/* hw/rv_pipeline_cpu.sv */
// Five-stage RV32I subset CPU top joining fetch, decode, execute and memory stages
`default_nettype none

module rv_pipeline_cpu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,        // PC advance enable
    output logic [rv_isa_pkg::xlen-1:0] data_mem0   // Data RAM word 0
);

    // ====================================================================
    // Stage to stage buses
    // ====================================================================
    rv_pipe_pkg::if_id_t    if_id;
    rv_pipe_pkg::id_ex_t    id_ex;
    rv_pipe_pkg::ex_mem_t   ex_mem;
    rv_pipe_pkg::mem_wb_t   mem_wb;
    rv_pipe_pkg::redirect_t redirect;   // From memory stage, flushes IF, ID, EX
    rv_pipe_pkg::wb_t       wb;         // Writeback and MEM/WB forward

    rv_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .redirect (redirect),
        .if_id    (if_id)
    );

    rv_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .mem_wb   (mem_wb),
        .redirect (redirect),
        .id_ex    (id_ex),
        .wb       (wb)
    );

    rv_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .wb       (wb),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    rv_memory u_memory (
        .clk       (clk),
        .rst       (rst),
        .ex_mem    (ex_mem),
        .redirect  (redirect),
        .mem_wb    (mem_wb),
        .data_mem0 (data_mem0)
    );

endmodule

`default_nettype wire

/* dv/tb_rv_pipeline_cpu.sv */
// Testbench with clock, reset, run control, expected word 0 signatures and checking assertions
`default_nettype none

module tb_rv_pipeline_cpu;

    localparam int num_sigs    = 6;
    localparam int max_wait    = 400;    // Cycles allowed after run rises
    localparam int quiet_after = 20;     // Watch for stray stores at the end

    // Word 0 values in program order, derived in dv/program.hex
    localparam logic [rv_isa_pkg::xlen-1:0] sigs [num_sigs] = '{
        32'h0000_0011,      // 5 + 12
        32'hFFFF_FFF9,      // 5 - 12
        32'h1234_5000,      // lui 0x12345
        32'h1234_0500,      // Byte 1 now 0x05
        32'h0000_000A,      // Loaded 5, doubled
        32'h0000_0058       // Link of jal at 0x54
    };

    logic                        clk;
    logic                        rst;
    logic                        run;
    logic [rv_isa_pkg::xlen-1:0] data_mem0;

    logic [rv_isa_pkg::xlen-1:0] prev_word;   // Word 0 one edge earlier
    int                          sig_idx;     // Signatures seen so far
    int                          run_low;     // Cycles with run held low
    int                          cyc;

    rv_pipeline_cpu dut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .data_mem0 (data_mem0)
    );

    // Test name for each signature slot
    function automatic string sig_name(input int idx);
        case (idx)
            0:       return "fwd_add";
            1:       return "fwd_sub";
            2:       return "lui_word";
            3:       return "sb_merge";
            4:       return "lb_sign_ext";
            5:       return "beq_jal_link";
            default: return "none";
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================================================================
    // Signature tracking
    // ====================================================================
    // Counts word 0 changes; DUT updates land after this block reads them
    always @(posedge clk) begin
        if (rst) begin
            prev_word <= '0;
            sig_idx   <= 0;
        end else begin
            prev_word <= data_mem0;
            if (data_mem0 != prev_word) begin
                sig_idx <= sig_idx + 1;     // Change at the previous edge
            end
        end
    end

    // ====================================================================
    // Checks, on the falling edge where every DUT output is settled
    // ====================================================================
    // Nothing may reach word 0 before the core runs
    run_low_hold: assert property (@(negedge clk) disable iff (rst)
        !run |-> data_mem0 == '0)
    else begin
        $display("ERROR: run_low_hold expected 0x%08h actual 0x%08h", 32'h0, data_mem0);
        $display("test failed");
        $fatal(1, "data word 0 changed while run was low");
    end

    // Each change must be the next listed signature, so a missed flush shows up
    sig_order: assert property (@(negedge clk) disable iff (rst)
        (data_mem0 != prev_word) |-> (sig_idx < num_sigs && data_mem0 == sigs[sig_idx]))
    else begin
        if (sig_idx < num_sigs) begin
            $display("ERROR: %s expected 0x%08h actual 0x%08h",
                     sig_name(sig_idx), sigs[sig_idx], data_mem0);
        end else begin
            $display("ERROR: store of 0x%08h to data word 0 after the last signature",
                     data_mem0);
        end
        $display("test failed");
        $fatal(1, "data word 0 left the expected sequence");
    end

    // ====================================================================
    // Stimulus
    // ====================================================================
    initial begin
        rst = 1'b1;
        run = 1'b0;
        void'($urandom(32'h78cc));              // One seed for the whole run
        run_low = 10 + int'($urandom % 21);     // 10 to 30 cycles

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Core spins on the first nop meanwhile
        repeat (run_low) @(posedge clk);
        run <= 1'b1;

        for (cyc = 0; cyc < max_wait && sig_idx < num_sigs; cyc++) begin
            @(negedge clk);
        end

        if (sig_idx < num_sigs) begin
            $display("Timeout: signature %0d (%s, 0x%08h) never reached data word 0",
                     sig_idx, sig_name(sig_idx), sigs[sig_idx]);
            $display("test failed");
            $fatal(1, "timeout after %0d cycles of run", max_wait);
        end else begin
            repeat (quiet_after) @(negedge clk);   // Self loop, no more stores
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memory.sv
hw/rv_pipeline_cpu.sv
dv/tb_rv_pipeline_cpu.sv

/* Makefile */
# Verilator build and run of the pipelined RV32I subset CPU testbench

BIN  := obj_dir/Vtb_rv_pipeline_cpu
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: $(BIN)
	./$(BIN) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_rv_pipeline_cpu -f sources.f

clean:
	rm -rf obj_dir

/* dv/program.hex */
// Column 1 is the instruction word in hex, one word per address starting at 0x00
// Comment gives the byte address, the assembly and the data word 0 value it leads to
00000013  // 0x00 nop, fetched over and over while run is low
00000013  // 0x04 nop
00000013  // 0x08 nop
00500093  // 0x0C addi x1, x0, 5
00C00113  // 0x10 addi x2, x0, 12
002081B3  // 0x14 add  x3, x1, x2      x3 = 5 + 12 = 0x11
40208233  // 0x18 sub  x4, x1, x2      x4 = 5 - 12 = 0xFFFFFFF9
00302023  // 0x1C sw   x3, 0(x0)       word 0 = 0x00000011
00402023  // 0x20 sw   x4, 0(x0)       word 0 = 0xFFFFFFF9
123452B7  // 0x24 lui  x5, 0x12345     x5 = 0x12345000
00502023  // 0x28 sw   x5, 0(x0)       word 0 = 0x12345000
00500313  // 0x2C addi x6, x0, 5
006000A3  // 0x30 sb   x6, 1(x0)       byte 1 goes 0x50 to 0x05, word 0 = 0x12340500
00100383  // 0x34 lb   x7, 1(x0)       x7 = sign extended 0x05 = 5
00100413  // 0x38 addi x8, x0, 1       independent slot after the load
007384B3  // 0x3C add  x9, x7, x7      x9 = 5 + 5 = 10
00902023  // 0x40 sw   x9, 0(x0)       word 0 = 0x0000000A
0000E537  // 0x44 lui  x10, 0xE        x10 = 0x0000E000
00000663  // 0x48 beq  x0, x0, +12     always taken to 0x54
EAD50513  // 0x4C addi x10, x10, -339  0xE000 - 0x153 = 0xDEAD, squashed
00A02023  // 0x50 sw   x10, 0(x0)      would write 0xDEAD, squashed
0080066F  // 0x54 jal  x12, +8         to 0x5C, x12 = 0x54 + 4 = 0x58
00A02023  // 0x58 sw   x10, 0(x0)      would write 0xE000, squashed
00C02023  // 0x5C sw   x12, 0(x0)      word 0 = 0x00000058
0000006F  // 0x60 jal  x0, 0           self loop
00000013  // 0x64 nop
00000013  // 0x68 nop
00000013  // 0x6C nop
